/* pcie_core_pkg.sv */
/*
 * pcie core package
 * request kinds, completion status codes, the BAR0 register map,
 * field widths and the bit positions of the CQ and CC beats
 */
package pcie_core_pkg;

    localparam int ADDR_W = 12;
    localparam int TAG_W  = 8;
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;
    localparam int BEAT_W = 64;
    localparam int PEND_W = 4;

    typedef enum logic [1:0] {
        KIND_MEM_READ    = 2'd0,
        KIND_MEM_WRITE   = 2'd1,
        KIND_UNSUPPORTED = 2'd2
    } req_kind_t;

    typedef enum logic [1:0] {
        CPL_SC = 2'd0,
        CPL_UR = 2'd1
    } cpl_status_t;

    // BAR0 map, byte offsets
    localparam logic [ADDR_W-1:0] REG_ID          = 12'h000;
    localparam logic [ADDR_W-1:0] REG_SCRATCH     = 12'h004;
    localparam logic [ADDR_W-1:0] REG_CONTROL     = 12'h008;
    localparam logic [ADDR_W-1:0] REG_DOORBELL    = 12'h00C;
    localparam logic [ADDR_W-1:0] REG_IRQ_COUNT   = 12'h010;
    localparam logic [ADDR_W-1:0] REG_MAX_PAYLOAD = 12'h014;

    localparam int CTRL_IRQ_EN_BIT = 0;

    localparam logic [DATA_W-1:0] CORE_ID = 32'h5043_4530;

    // cq beat: kind, tag, be, offset, 6 spare, data
    localparam int CQ_KIND_LSB   = 62;
    localparam int CQ_TAG_LSB    = 54;
    localparam int CQ_BE_LSB     = 50;
    localparam int CQ_OFFSET_LSB = 38;
    localparam int CQ_DATA_LSB   = 0;

    // cc beat: tag, status, 22 spare, data
    localparam int CC_TAG_LSB    = 56;
    localparam int CC_STATUS_LSB = 54;
    localparam int CC_DATA_LSB   = 0;

endpackage

/* pcie_req_if.sv */
/*
 * decoded request bus
 * carries one BAR0 request from the decoder to the register block,
 * watched by the completion builder, which owns ready
 */
`timescale 1ns/1ns

interface pcie_req_if;
    import pcie_core_pkg::*;

    logic              valid;
    logic              ready;
    req_kind_t         kind;
    logic [TAG_W-1:0]  tag;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] offset;
    logic [DATA_W-1:0] wdata;

    modport producer (
        output valid, kind, tag, be, offset, wdata,
        input  ready
    );

    modport target (
        input valid, ready, kind, be, offset, wdata
    );

    modport monitor (
        input  valid, kind, tag,
        output ready
    );

endinterface

/* cq_request_decoder.sv */
/*
 * completer request decoder
 * one-entry register stage that splits a CQ beat into request fields
 * and holds the request while the completion side is stalled
 */
`timescale 1ns/1ns

module cq_request_decoder (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cq_valid,
    output logic                             cq_ready,
    input  logic [pcie_core_pkg::BEAT_W-1:0] cq_data,
    pcie_req_if.producer                     req
);
    import pcie_core_pkg::*;

    logic       running;
    logic       full;
    logic [1:0] kind_code;
    req_kind_t  kind_dec;

    assign kind_code = cq_data[CQ_KIND_LSB +: 2];

    // unknown codes fold into unsupported
    always_comb begin
        case (kind_code)
            KIND_MEM_READ:  kind_dec = KIND_MEM_READ;
            KIND_MEM_WRITE: kind_dec = KIND_MEM_WRITE;
            default:        kind_dec = KIND_UNSUPPORTED;
        endcase
    end

    // accept when empty or when the held request leaves this cycle
    assign cq_ready  = running && (!full || req.ready);
    assign req.valid = full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            full    <= 1'b0;
        end else begin
            running <= 1'b1;
            if (cq_ready) begin
                full <= cq_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cq_valid && cq_ready) begin
            req.kind   <= kind_dec;
            req.tag    <= cq_data[CQ_TAG_LSB +: TAG_W];
            req.be     <= cq_data[CQ_BE_LSB +: BE_W];
            req.offset <= cq_data[CQ_OFFSET_LSB +: ADDR_W];
            req.wdata  <= cq_data[CQ_DATA_LSB +: DATA_W];
        end
    end

endmodule

/* bar_register_file.sv */
/*
 * BAR0 register block
 * scratch and control with byte-enabled writes, read-only id,
 * interrupt count and max payload mirror, doorbell pulse output
 */
`timescale 1ns/1ns

module bar_register_file (
    input  logic                             clk,
    input  logic                             rst_n,
    pcie_req_if.target                       req,
    output logic [pcie_core_pkg::DATA_W-1:0] rdata,
    output pcie_core_pkg::cpl_status_t       rstatus,
    input  logic [2:0]                       cfg_max_payload,
    input  logic [pcie_core_pkg::DATA_W-1:0] irq_count,
    output logic                             doorbell
);
    import pcie_core_pkg::*;

    logic [DATA_W-1:0] scratch;
    logic [DATA_W-1:0] control;
    logic              wr_en;

    function automatic logic [DATA_W-1:0] merge_be(
        input logic [DATA_W-1:0] old_val,
        input logic [DATA_W-1:0] new_val,
        input logic [BE_W-1:0]   be
    );
        logic [DATA_W-1:0] result;
        result = old_val;
        for (int i = 0; i < BE_W; i++) begin
            if (be[i]) begin
                result[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign wr_en = req.valid && req.ready && (req.kind == KIND_MEM_WRITE);

    // same cycle as the transfer so the pending count moves on the next edge
    assign doorbell = wr_en && (req.offset == REG_DOORBELL) && control[CTRL_IRQ_EN_BIT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch <= '0;
            control <= '0;
        end else if (wr_en) begin
            if (req.offset == REG_SCRATCH) begin
                scratch <= merge_be(scratch, req.wdata, req.be);
            end
            if (req.offset == REG_CONTROL) begin
                control <= merge_be(control, req.wdata, req.be);
            end
        end
    end

    always_comb begin
        rdata   = '0;
        rstatus = CPL_SC;
        case (req.offset)
            REG_ID:          rdata = CORE_ID;
            REG_SCRATCH:     rdata = scratch;
            REG_CONTROL:     rdata = control;
            // write only, reads back zero
            REG_DOORBELL:    rdata = '0;
            REG_IRQ_COUNT:   rdata = irq_count;
            REG_MAX_PAYLOAD: rdata = {{(DATA_W-3){1'b0}}, cfg_max_payload};
            default:         rstatus = CPL_UR;
        endcase
        if (req.kind == KIND_UNSUPPORTED) begin
            rdata   = '0;
            rstatus = CPL_UR;
        end
    end

endmodule

/* cc_completion_builder.sv */
/*
 * completer completion builder
 * registers one read completion (tag, status, data) and holds it
 * on the CC stream until the host side takes it
 */
`timescale 1ns/1ns

module cc_completion_builder (
    input  logic                             clk,
    input  logic                             rst_n,
    pcie_req_if.monitor                      req,
    input  logic [pcie_core_pkg::DATA_W-1:0] rdata,
    input  pcie_core_pkg::cpl_status_t       rstatus,
    output logic                             cc_valid,
    input  logic                             cc_ready,
    output logic [pcie_core_pkg::BEAT_W-1:0] cc_data
);
    import pcie_core_pkg::*;

    logic              rd_xfer;
    logic [BEAT_W-1:0] beat;

    // free slot, or the held beat leaves this cycle
    assign req.ready = !cc_valid || cc_ready;
    assign rd_xfer   = req.valid && req.ready && (req.kind == KIND_MEM_READ);

    always_comb begin
        beat = '0;
        beat[CC_TAG_LSB +: TAG_W]    = req.tag;
        beat[CC_STATUS_LSB +: 2]     = rstatus;
        beat[CC_DATA_LSB +: DATA_W]  = rdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cc_valid <= 1'b0;
        end else if (req.ready) begin
            cc_valid <= rd_xfer;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_xfer) begin
            cc_data <= beat;
        end
    end

endmodule

/* msix_doorbell.sv */
/*
 * doorbell interrupt generator
 * saturating count of pending doorbells feeding a four-phase
 * req/ack handshake, one handshake per pending doorbell
 */
`timescale 1ns/1ns

module msix_doorbell (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             doorbell,
    output logic                             irq_req,
    input  logic                             irq_ack,
    output logic [pcie_core_pkg::DATA_W-1:0] irq_count
);
    import pcie_core_pkg::*;

    typedef enum logic [1:0] {
        IRQ_IDLE,
        IRQ_REQ,
        IRQ_WAIT_LOW
    } irq_state_t;

    irq_state_t        state;
    logic [PEND_W-1:0] pending;
    logic              ack_done;

    // handshake ends when the host drops ack
    assign ack_done = (state == IRQ_WAIT_LOW) && !irq_ack;
    assign irq_req  = (state == IRQ_REQ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IRQ_IDLE;
            pending   <= '0;
            irq_count <= '0;
        end else begin
            case ({doorbell, ack_done})
                2'b10: if (pending != '1) pending <= pending + 1'b1;
                2'b01: pending <= pending - 1'b1;
                default: ;
            endcase
            case (state)
                IRQ_IDLE:     if (pending != '0) state <= IRQ_REQ;
                IRQ_REQ:      if (irq_ack) state <= IRQ_WAIT_LOW;
                IRQ_WAIT_LOW: if (!irq_ack) state <= IRQ_IDLE;
                default:      state <= IRQ_IDLE;
            endcase
            if (ack_done) begin
                irq_count <= irq_count + 1'b1;
            end
        end
    end

endmodule

/* pcie_core_top.sv */
/*
 * pcie core top
 * BAR0 register access core: CQ decoder, register block,
 * CC completion builder and doorbell interrupt
 */
`timescale 1ns/1ns

module pcie_core_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cq_valid,
    output logic                             cq_ready,
    input  logic [pcie_core_pkg::BEAT_W-1:0] cq_data,
    output logic                             cc_valid,
    input  logic                             cc_ready,
    output logic [pcie_core_pkg::BEAT_W-1:0] cc_data,
    input  logic [2:0]                       cfg_max_payload,
    output logic                             irq_req,
    input  logic                             irq_ack
);
    import pcie_core_pkg::*;

    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] irq_count;
    cpl_status_t       rstatus;
    logic              doorbell;

    pcie_req_if req_bus ();

    cq_request_decoder
    decoder_inst (
        .clk(clk),
        .rst_n(rst_n),
        .cq_valid(cq_valid),
        .cq_ready(cq_ready),
        .cq_data(cq_data),
        .req(req_bus.producer)
    );

    bar_register_file
    regs_inst (
        .clk(clk),
        .rst_n(rst_n),
        .req(req_bus.target),
        .rdata(rdata),
        .rstatus(rstatus),
        .cfg_max_payload(cfg_max_payload),
        .irq_count(irq_count),
        .doorbell(doorbell)
    );

    cc_completion_builder
    cpl_inst (
        .clk(clk),
        .rst_n(rst_n),
        .req(req_bus.monitor),
        .rdata(rdata),
        .rstatus(rstatus),
        .cc_valid(cc_valid),
        .cc_ready(cc_ready),
        .cc_data(cc_data)
    );

    msix_doorbell
    irq_inst (
        .clk(clk),
        .rst_n(rst_n),
        .doorbell(doorbell),
        .irq_req(irq_req),
        .irq_ack(irq_ack),
        .irq_count(irq_count)
    );

endmodule

/* pcie_core_assertions.sv */
/*
 * protocol checks on the pcie core boundary
 * CC beat hold under back-pressure and the four-phase interrupt pair
 */
`timescale 1ns/1ns

module pcie_core_assertions (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             cc_valid,
    input logic                             cc_ready,
    input logic [pcie_core_pkg::BEAT_W-1:0] cc_data,
    input logic                             irq_req,
    input logic                             irq_ack
);

    // a stalled beat stays put
    cc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cc_valid && !cc_ready |=> cc_valid && $stable(cc_data))
        else $error("cc beat changed while stalled");

    // request stays up until the host acks
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        irq_req && !irq_ack |=> irq_req)
        else $error("irq_req fell before irq_ack");

    // no new request until ack is low again
    req_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !irq_req && irq_ack |=> !irq_req)
        else $error("irq_req rose while irq_ack was high");

endmodule

bind pcie_core_top pcie_core_assertions assertions_inst (
    .clk(clk),
    .rst_n(rst_n),
    .cc_valid(cc_valid),
    .cc_ready(cc_ready),
    .cc_data(cc_data),
    .irq_req(irq_req),
    .irq_ack(irq_ack)
);

/* tb_pcie_core.sv */
/*
 * testbench for the pcie core
 * host model on CQ, CC and the interrupt pair, table driven requests,
 * completions checked in order against a small register model
 */
`timescale 1ns/1ns

module tb_pcie_core;
    import pcie_core_pkg::*;

    localparam int TIMEOUT = 400;

    typedef struct packed {
        req_kind_t         kind;
        logic [TAG_W-1:0]  tag;
        logic [ADDR_W-1:0] offset;
        logic [BE_W-1:0]   be;
        logic [DATA_W-1:0] wdata;
        logic              cpl;
        cpl_status_t       status;
        logic [DATA_W-1:0] data;
    } row_t;

    logic clk;
    logic rst_n;
    logic cq_valid;
    logic cq_ready;
    logic [BEAT_W-1:0] cq_data;
    logic cc_valid;
    logic cc_ready;
    logic [BEAT_W-1:0] cc_data;
    logic [2:0] cfg_max_payload;
    logic irq_req;
    logic irq_ack;

    row_t              rows[$];
    logic [TAG_W-1:0]  exp_tag[$];
    cpl_status_t       exp_status[$];
    logic [DATA_W-1:0] exp_data[$];
    logic [15:0]       lfsr;
    int                ack_wait;
    int                draw;
    int                handshakes;
    int                reads_sent;
    int                cpl_seen;
    logic [DATA_W-1:0] m_scratch;
    logic [DATA_W-1:0] m_control;
    logic [DATA_W-1:0] m_irqs;

    pcie_core_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_cpl(input logic [TAG_W-1:0] tag, input cpl_status_t status,
                             input logic [DATA_W-1:0] data, input logic [TAG_W-1:0] tag_exp,
                             input cpl_status_t status_exp, input logic [DATA_W-1:0] data_exp);
        if (tag !== tag_exp || status !== status_exp || data !== data_exp) begin
            report_mismatch($sformatf("completion tag %h status %0d data %h, expected %h %0d %h",
                                      tag, status, data, tag_exp, status_exp, data_exp));
        end
    endtask

    task automatic check_irq_count(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%0d interrupt handshakes seen, expected %0d", got, exp));
        end
    endtask

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [DATA_W-1:0] byte_merge(input logic [DATA_W-1:0] old_val,
                                                     input logic [DATA_W-1:0] new_val,
                                                     input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    task automatic add_row(input req_kind_t kind, input logic [TAG_W-1:0] tag,
                           input logic [ADDR_W-1:0] offset, input logic [BE_W-1:0] be,
                           input logic [DATA_W-1:0] wdata, input logic cpl,
                           input cpl_status_t status, input logic [DATA_W-1:0] data);
        rows.push_back({kind, tag, offset, be, wdata, cpl, status, data});
    endtask

    // waits until every enabled doorbell has had its handshake
    task automatic wait_irq_done();
        int waited;
        waited = 0;
        while ((waited < 8 || handshakes < m_irqs || irq_req || irq_ack) && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (waited >= TIMEOUT) report_error("interrupt handshakes did not finish in time");
        else check_irq_count(handshakes, m_irqs);
    endtask

    task automatic apply_row(input row_t r);
        logic [DATA_W-1:0] exp;
        logic [BEAT_W-1:0] beat;
        int waited;
        if (r.kind == KIND_MEM_READ && r.offset == REG_IRQ_COUNT) wait_irq_done();
        if (r.cpl) begin
            exp = r.data;
            // stateful registers come from the model
            case (r.offset)
                REG_SCRATCH:   exp = m_scratch;
                REG_CONTROL:   exp = m_control;
                REG_IRQ_COUNT: exp = m_irqs;
                default: ;
            endcase
            exp_tag.push_back(r.tag);
            exp_status.push_back(r.status);
            exp_data.push_back(exp);
            reads_sent++;
        end
        if (r.kind == KIND_MEM_WRITE) begin
            case (r.offset)
                REG_SCRATCH:  m_scratch = byte_merge(m_scratch, r.wdata, r.be);
                REG_CONTROL:  m_control = byte_merge(m_control, r.wdata, r.be);
                REG_DOORBELL: if (m_control[0]) m_irqs++;
                default: ;
            endcase
        end
        beat = '0;
        beat[CQ_KIND_LSB +: 2] = r.kind;
        beat[CQ_TAG_LSB +: TAG_W] = r.tag;
        beat[CQ_BE_LSB +: BE_W] = r.be;
        beat[CQ_OFFSET_LSB +: ADDR_W] = r.offset;
        beat[CQ_DATA_LSB +: DATA_W] = r.wdata;
        cq_valid = 1'b1;
        cq_data = beat;
        waited = 0;
        @(negedge clk);
        while (!cq_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= TIMEOUT) begin
            report_error("request was never accepted on the CQ stream");
        end else begin
            @(posedge clk);
            #1;
            cq_valid = 1'b0;
        end
    endtask

    // host side: random CC stalls and delayed interrupt acks
    initial begin
        lfsr = 16'd40;
        cc_ready = 1'b0;
        irq_ack = 1'b0;
        ack_wait = 0;
        handshakes = 0;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                #1;
                draw_bits(2, draw);
                cc_ready = (draw != 0);
                if (irq_req && !irq_ack) begin
                    if (ack_wait == 0) begin
                        irq_ack = 1'b1;
                        draw_bits(3, ack_wait);
                    end else begin
                        ack_wait--;
                    end
                end else if (!irq_req && irq_ack) begin
                    if (ack_wait == 0) begin
                        irq_ack = 1'b0;
                        handshakes++;
                        draw_bits(3, ack_wait);
                    end else begin
                        ack_wait--;
                    end
                end
            end
        end
    end

    // completions are checked before the edge that takes them
    initial begin
        cpl_seen = 0;
        forever begin
            @(negedge clk);
            if (rst_n && cc_valid && cc_ready) begin
                cpl_seen++;
                if (exp_tag.size() != 0) begin
                    check_cpl(cc_data[CC_TAG_LSB +: TAG_W],
                              cpl_status_t'(cc_data[CC_STATUS_LSB +: 2]),
                              cc_data[CC_DATA_LSB +: DATA_W], exp_tag.pop_front(),
                              exp_status.pop_front(), exp_data.pop_front());
                end
            end
        end
    end

    initial begin
        int waited;
        rst_n = 1'b0;
        cq_valid = 1'b0;
        cq_data = '0;
        cfg_max_payload = 3'd5;
        reads_sent = 0;
        m_scratch = '0;
        m_control = '0;
        m_irqs = '0;
        add_row(KIND_MEM_READ, 8'h01, REG_ID, 4'hF, '0, 1'b1, CPL_SC, CORE_ID);
        add_row(KIND_MEM_READ, 8'h02, REG_MAX_PAYLOAD, 4'hF, '0, 1'b1, CPL_SC, 32'd5);
        add_row(KIND_MEM_WRITE, 8'h03, REG_SCRATCH, 4'hF, 32'hA5A5_1234, 1'b0, CPL_SC, '0);
        add_row(KIND_MEM_WRITE, 8'h04, REG_SCRATCH, 4'h6, 32'h1122_3344, 1'b0, CPL_SC, '0);
        add_row(KIND_MEM_READ, 8'h05, REG_SCRATCH, 4'hF, '0, 1'b1, CPL_SC, '0);
        add_row(KIND_MEM_WRITE, 8'h06, REG_ID, 4'hF, 32'h0, 1'b0, CPL_SC, '0);
        add_row(KIND_MEM_READ, 8'h07, REG_ID, 4'hF, '0, 1'b1, CPL_SC, CORE_ID);
        add_row(KIND_MEM_READ, 8'h08, 12'h020, 4'hF, '0, 1'b1, CPL_UR, '0);
        // back to back reads under stalls
        add_row(KIND_MEM_READ, 8'h10, REG_SCRATCH, 4'hF, '0, 1'b1, CPL_SC, '0);
        add_row(KIND_MEM_READ, 8'h11, REG_ID, 4'hF, '0, 1'b1, CPL_SC, CORE_ID);
        add_row(KIND_MEM_READ, 8'h12, REG_MAX_PAYLOAD, 4'hF, '0, 1'b1, CPL_SC, 32'd5);
        add_row(KIND_MEM_READ, 8'h13, REG_CONTROL, 4'hF, '0, 1'b1, CPL_SC, '0);
        add_row(KIND_MEM_READ, 8'h14, REG_DOORBELL, 4'hF, '0, 1'b1, CPL_SC, '0);
        // doorbells, first with the enable clear
        add_row(KIND_MEM_WRITE, 8'h20, REG_DOORBELL, 4'hF, 32'h1, 1'b0, CPL_SC, '0);
        add_row(KIND_MEM_WRITE, 8'h21, REG_CONTROL, 4'h1, 32'h1, 1'b0, CPL_SC, '0);
        add_row(KIND_MEM_WRITE, 8'h22, REG_DOORBELL, 4'hF, 32'h1, 1'b0, CPL_SC, '0);
        add_row(KIND_MEM_WRITE, 8'h23, REG_DOORBELL, 4'hF, 32'h1, 1'b0, CPL_SC, '0);
        add_row(KIND_MEM_WRITE, 8'h24, REG_DOORBELL, 4'hF, 32'h1, 1'b0, CPL_SC, '0);
        add_row(KIND_MEM_READ, 8'h25, REG_IRQ_COUNT, 4'hF, '0, 1'b1, CPL_SC, '0);
        add_row(KIND_MEM_READ, 8'h26, REG_CONTROL, 4'hF, '0, 1'b1, CPL_SC, '0);
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (rows[i]) apply_row(rows[i]);
        waited = 0;
        while (exp_tag.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= TIMEOUT) report_error("outstanding reads never completed");
        wait_irq_done();
        if (cpl_seen != reads_sent) begin
            report_mismatch($sformatf("%0d completions for %0d reads", cpl_seen, reads_sent));
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

/* list.f */
pcie_core_pkg.sv
pcie_req_if.sv
cq_request_decoder.sv
bar_register_file.sv
cc_completion_builder.sv
msix_doorbell.sv
pcie_core_top.sv
pcie_core_assertions.sv
tb_pcie_core.sv

/* Bender.yml */
package:
  name: pcie_core

sources:
  - pcie_core_pkg.sv
  - pcie_req_if.sv
  - cq_request_decoder.sv
  - bar_register_file.sv
  - cc_completion_builder.sv
  - msix_doorbell.sv
  - pcie_core_top.sv
  - target: simulation
    files:
      - pcie_core_assertions.sv
      - tb_pcie_core.sv
